// File: hw/timed_tx_cfg.svh
`ifndef TIMED_TX_CFG_SVH
`define TIMED_TX_CFG_SVH

// slot memory address width, 1024 words of 16 bits
// host and sender pointers are this wide
`define TX_RAM_AW 10

// local clocks, selects 1 to 7 are valid
`define N_LOCAL_CLK 7

// minimum idle clocks between two frames on GMII
`define IFG_CYCLES 12

// preamble bytes plus SFD
`define PREAMBLE_LEN 8

// header words in front of the payload of each record
`define HDR_WORDS 7

`endif

// File: hw/timed_tx_pkg.sv
`include "timed_tx_cfg.svh"

package timed_tx_pkg;

  // record layout in the slot memory, one 16-bit word per address:
  //   word 0      frame length in payload bytes
  //   words 1..4  schedule word, most significant word first
  //   words 5..6  hash, high word first
  //   then ceil(len/2) payload words, high byte goes out first
  // a record takes 7 + ceil(len/2) words, addresses wrap

  // schedule word as the sender decodes it
  typedef struct packed {
    logic        is_cmd;
    logic [2:0]  clk_sel;
    logic [11:0] reserved;
    logic [47:0] rel_time;
  } tx_sched_s;

  // raw view is filled from memory, fields view decides release
  typedef union packed {
    logic [63:0] raw;
    tx_sched_s   fields;
  } tx_sched_u;

  typedef struct packed {
    logic [15:0] frame_len;
    tx_sched_u   sched;
    logic [31:0] hash;
  } tx_rec_s;

  typedef struct packed {
    logic [`TX_RAM_AW-1:0] addr;
    logic [15:0]           data;
  } host_wr_s;

endpackage

// File: hw/tx_slot_ram.sv
`timescale 1ns/100ps
`default_nettype none
`include "timed_tx_cfg.svh"

module tx_slot_ram (
  input  logic                  gmii_tx_clk,
  input  timed_tx_pkg::host_wr_s host_wr,
  input  logic                  host_wr_valid,
  input  logic [`TX_RAM_AW-1:0] rd_addr,
  output logic [15:0]           rd_data
);

  localparam int DEPTH = 1 << `TX_RAM_AW;

  logic [15:0] mem [0:DEPTH-1];

  // host port, one word per strobe
  always_ff @(posedge gmii_tx_clk) begin
    if (host_wr_valid) begin
      mem[host_wr.addr] <= host_wr.data;
    end
  end

  // sender port, data one cycle after the address
  always_ff @(posedge gmii_tx_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/eth_crc32.sv
`timescale 1ns/100ps
`default_nettype none

module eth_crc32 (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic        crc_init,
  input  logic        crc_data_en,
  input  logic [7:0]  crc_byte,
  output logic [31:0] crc_value
);

  localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

  function automatic logic [31:0] reflect32(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  // LSB-first form of the polynomial
  localparam logic [31:0] POLY_REFL = reflect32(CRC_POLY);

  // one byte, bit 0 first as on the wire
  function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] x;
    x = c;
    for (int i = 0; i < 8; i++) begin
      if (x[0] ^ d[i]) begin
        x = (x >> 1) ^ POLY_REFL;
      end else begin
        x = x >> 1;
      end
    end
    return x;
  endfunction

  logic [31:0] crc_q;
  logic [31:0] crc_seed;

  // init folds the all-ones preset into the first byte
  assign crc_seed = crc_init ? 32'hFFFF_FFFF : crc_q;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      crc_q <= 32'hFFFF_FFFF;
    end else if (crc_data_en) begin
      crc_q <= crc_next(crc_seed, crc_byte);
    end else if (crc_init) begin
      crc_q <= 32'hFFFF_FFFF;
    end
  end

  // complemented, byte to send first in [31:24]
  assign crc_value = {~crc_q[7:0], ~crc_q[15:8], ~crc_q[23:16], ~crc_q[31:24]};

endmodule

`default_nettype wire

// File: hw/timebase.sv
`timescale 1ns/100ps
`default_nettype none
`include "timed_tx_cfg.svh"

module timebase (
  input  logic                          gmii_tx_clk,
  input  logic                          sys_rst,
  input  logic [`N_LOCAL_CLK-1:0]       local_time_req,
  output logic [63:0]                   global_counter,
  output logic [`N_LOCAL_CLK-1:0][47:0] local_epoch
);

  // free-running global time
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      global_counter <= 64'd0;
    end else begin
      global_counter <= global_counter + 64'd1;
    end
  end

  // epoch k sits at index k-1
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      local_epoch <= '0;
    end else begin
      for (int i = 0; i < `N_LOCAL_CLK; i++) begin
        if (local_time_req[i]) begin
          local_epoch[i] <= global_counter[47:0];
        end
      end
    end
  end

  // the sender services one command record at a time
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    $onehot0(local_time_req));

endmodule

`default_nettype wire

// File: hw/frame_sender.sv
`timescale 1ns/100ps
`default_nettype none
`include "timed_tx_cfg.svh"

module frame_sender (
  input  logic                          gmii_tx_clk,
  input  logic                          sys_rst,
  input  logic [`TX_RAM_AW-1:0]         mem_wr_ptr,
  output logic [`TX_RAM_AW-1:0]         mem_rd_ptr,
  output logic [`TX_RAM_AW-1:0]         rd_addr,
  input  logic [15:0]                   rd_data,
  input  logic [63:0]                   global_counter,
  input  logic [`N_LOCAL_CLK-1:0][47:0] local_epoch,
  output logic [`N_LOCAL_CLK-1:0]       local_time_req,
  output logic                          crc_init,
  output logic                          crc_data_en,
  output logic [7:0]                    crc_byte,
  input  logic [31:0]                   crc_value,
  output logic [7:0]                    gmii_txd,
  output logic                          gmii_tx_en
);

  import timed_tx_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MEMWAIT,
    ST_HDR_LOAD,
    ST_WAITING,
    ST_SENDING,
    ST_FCS_1,
    ST_FCS_2,
    ST_FCS_3
  } state_e;

  localparam int GAP_W = $clog2(`IFG_CYCLES + 1);
  localparam logic [GAP_W-1:0] GAP_DONE = GAP_W'(`IFG_CYCLES);
  localparam logic [16:0] SFD_POS = 17'(`PREAMBLE_LEN - 1);
  localparam logic [16:0] PAY_START = 17'(`PREAMBLE_LEN);
  localparam logic [2:0] HDR_LAST = 3'(`HDR_WORDS - 1);

  state_e                state;
  tx_rec_s               rec;
  logic [`TX_RAM_AW-1:0] rd_ptr;
  logic [2:0]            hdr_cnt;
  logic [16:0]           tx_cnt;
  logic [16:0]           fcs_pos;
  logic [16:0]           pay_idx;
  logic [GAP_W-1:0]      gap_cnt;
  logic [63:0]           rel_target;
  logic                  release_ok;
  logic                  in_payload;

  assign rd_addr = rd_ptr;

  // release moment, local selects add the epoch of that clock
  always_comb begin
    rel_target = 64'(rec.sched.fields.rel_time);
    if (rec.sched.fields.clk_sel != 3'd0) begin
      rel_target = rel_target + 64'(local_epoch[rec.sched.fields.clk_sel - 3'd1]);
    end
    release_ok = (gap_cnt == GAP_DONE) &&
                 (rec.sched.fields.is_cmd || (global_counter >= rel_target));
  end

  // byte index in the frame being loaded into gmii_txd
  assign fcs_pos = {1'b0, rec.frame_len} + PAY_START;
  assign pay_idx = tx_cnt - PAY_START;
  assign in_payload = (state == ST_SENDING) && (tx_cnt >= PAY_START) && (tx_cnt < fcs_pos);

  // even payload bytes take the high half of the word
  assign crc_byte = pay_idx[0] ? rd_data[7:0] : rd_data[15:8];
  assign crc_data_en = in_payload;
  assign crc_init = in_payload && (tx_cnt == PAY_START);

  // header words land one per cycle
  always_ff @(posedge gmii_tx_clk) begin
    if (state == ST_HDR_LOAD) begin
      case (hdr_cnt)
        3'd0: rec.frame_len <= rd_data;
        3'd1: rec.sched.raw[63:48] <= rd_data;
        3'd2: rec.sched.raw[47:32] <= rd_data;
        3'd3: rec.sched.raw[31:16] <= rd_data;
        3'd4: rec.sched.raw[15:0] <= rd_data;
        3'd5: rec.hash[31:16] <= rd_data;
        default: rec.hash[15:0] <= rd_data;
      endcase
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state          <= ST_IDLE;
      rd_ptr         <= '0;
      mem_rd_ptr     <= '0;
      hdr_cnt        <= 3'd0;
      tx_cnt         <= 17'd0;
      gap_cnt        <= '0;
      local_time_req <= '0;
      gmii_txd       <= 8'h00;
      gmii_tx_en     <= 1'b0;
    end else begin
      local_time_req <= '0;

      // saturating idle count since the last FCS byte
      if (gap_cnt != GAP_DONE) begin
        gap_cnt <= gap_cnt + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          gmii_tx_en <= 1'b0;
          gmii_txd   <= 8'h00;
          hdr_cnt    <= 3'd0;
          // rd_ptr already points past the finished record
          mem_rd_ptr <= rd_ptr;
          if (rd_ptr != mem_wr_ptr) begin
            state <= ST_MEMWAIT;
          end
        end
        ST_MEMWAIT: begin
          rd_ptr <= rd_ptr + 1'b1;
          state  <= ST_HDR_LOAD;
        end
        ST_HDR_LOAD: begin
          hdr_cnt <= hdr_cnt + 3'd1;
          // stop on the first payload word
          if (hdr_cnt != HDR_LAST) begin
            rd_ptr <= rd_ptr + 1'b1;
          end else begin
            state <= ST_WAITING;
          end
        end
        ST_WAITING: begin
          if (release_ok) begin
            gmii_tx_en <= 1'b1;
            gmii_txd   <= 8'h55;
            tx_cnt     <= 17'd1;
            state      <= ST_SENDING;
            // select 0 on a command is accepted and ignored
            if (rec.sched.fields.is_cmd && (rec.sched.fields.clk_sel != 3'd0)) begin
              local_time_req[rec.sched.fields.clk_sel - 3'd1] <= 1'b1;
            end
          end
        end
        ST_SENDING: begin
          gmii_tx_en <= 1'b1;
          tx_cnt     <= tx_cnt + 17'd1;
          if (tx_cnt < SFD_POS) begin
            gmii_txd <= 8'h55;
          end else if (tx_cnt == SFD_POS) begin
            gmii_txd <= 8'hD5;
          end else if (in_payload) begin
            gmii_txd <= crc_byte;
            // next word is fetched while the low byte goes out
            if (!pay_idx[0]) begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end else begin
            gmii_txd <= crc_value[31:24];
            state    <= ST_FCS_1;
          end
        end
        ST_FCS_1: begin
          gmii_txd <= crc_value[23:16];
          state    <= ST_FCS_2;
        end
        ST_FCS_2: begin
          gmii_txd <= crc_value[15:8];
          state    <= ST_FCS_3;
        end
        default: begin
          gmii_txd <= crc_value[7:0];
          gap_cnt  <= '0;
          state    <= ST_IDLE;
        end
      endcase
    end
  end

  // frames end only after the last FCS byte
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    $fell(gmii_tx_en) |-> ($past(state, 2) == ST_FCS_3));

  // minimum inter-frame gap on the wire
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    $fell(gmii_tx_en) |-> !gmii_tx_en [*`IFG_CYCLES]);

endmodule

`default_nettype wire

// File: hw/timed_tx_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "timed_tx_cfg.svh"

module timed_tx_top (
  input  logic                   gmii_tx_clk,
  input  logic                   sys_rst,
  input  timed_tx_pkg::host_wr_s host_wr,
  input  logic                   host_wr_valid,
  input  logic [`TX_RAM_AW-1:0]  mem_wr_ptr,
  output logic [`TX_RAM_AW-1:0]  mem_rd_ptr,
  output logic [7:0]             gmii_txd,
  output logic                   gmii_tx_en,
  output logic [63:0]            global_counter
);

  logic [`TX_RAM_AW-1:0]         rd_addr;
  logic [15:0]                   rd_data;
  logic [`N_LOCAL_CLK-1:0]       local_time_req;
  logic [`N_LOCAL_CLK-1:0][47:0] local_epoch;
  logic                          crc_init;
  logic                          crc_data_en;
  logic [7:0]                    crc_byte;
  logic [31:0]                   crc_value;

  tx_slot_ram tx_slot_ram_inst (
    .gmii_tx_clk   (gmii_tx_clk),
    .host_wr       (host_wr),
    .host_wr_valid (host_wr_valid),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  timebase timebase_inst (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .local_time_req (local_time_req),
    .global_counter (global_counter),
    .local_epoch    (local_epoch)
  );

  frame_sender frame_sender_inst (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .mem_wr_ptr     (mem_wr_ptr),
    .mem_rd_ptr     (mem_rd_ptr),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .global_counter (global_counter),
    .local_epoch    (local_epoch),
    .local_time_req (local_time_req),
    .crc_init       (crc_init),
    .crc_data_en    (crc_data_en),
    .crc_byte       (crc_byte),
    .crc_value      (crc_value),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en)
  );

  // FCS over the payload bytes only
  eth_crc32 eth_crc32_inst (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .crc_data_en (crc_data_en),
    .crc_byte    (crc_byte),
    .crc_value   (crc_value)
  );

endmodule

`default_nettype wire

// File: tb/tx_checker.sv
`timescale 1ns/100ps
`include "timed_tx_cfg.svh"

module tx_checker #(
  parameter int TD_WORDS = 128
) (
  input  logic                  gmii_tx_clk,
  input  logic                  sys_rst,
  input  logic [15:0]           tdata [0:TD_WORDS-1],
  input  logic [`TX_RAM_AW-1:0] mem_wr_ptr,
  input  logic [`TX_RAM_AW-1:0] mem_rd_ptr,
  input  logic [7:0]            gmii_txd,
  input  logic                  gmii_tx_en,
  input  logic [63:0]           global_counter,
  output int                    frames_done,
  output int                    fail_cnt
);

  localparam int AW = `TX_RAM_AW;

  logic [7:0]    got [$];
  logic [63:0]   epoch [0:7];
  logic [AW-1:0] exp_ptr;
  logic [63:0]   exp_cnt;
  logic [63:0]   first_cnt;
  logic          prev_en;
  logic          rst_seen = 1'b0;
  int            low_cnt;
  int            gap;

  // word offset of record r in the data array
  function automatic int rec_offset(input int r);
    int off;
    off = 1;
    for (int k = 0; k < r; k++) begin
      off = off + 6 + (int'(tdata[off+5]) + 1) / 2;
    end
    return off;
  endfunction

  function automatic logic [7:0] payload_byte(input int off, input int i);
    logic [15:0] w;
    w = tdata[off + 6 + i / 2];
    return (i % 2 == 0) ? w[15:8] : w[7:0];
  endfunction

  // reference FCS with the reflected polynomial and bit 0 first
  function automatic logic [31:0] eth_fcs(input int off, input int len);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++) begin
      c = c ^ {24'h0, payload_byte(off, i)};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic check_frame();
    int          off;
    int          len;
    int          errs;
    logic [63:0] sched;
    logic [63:0] target;
    logic [31:0] fcs;
    logic [7:0]  exp_b;
    if (frames_done >= int'(tdata[0])) begin
      $display("an extra frame went out after the last record");
      fail_cnt = fail_cnt + 1;
      return;
    end
    off   = rec_offset(frames_done);
    len   = int'(tdata[off+5]);
    sched = {tdata[off+1], tdata[off+2], tdata[off+3], tdata[off+4]};
    fcs   = eth_fcs(off, len);
    errs  = 0;
    if (got.size() != len + 12) begin
      $display("[FAIL] gmii_tx_en high cycles, frame %0d: expected 0x%0h got 0x%0h",
               frames_done, len + 12, got.size());
      errs = errs + 1;
    end else begin
      for (int i = 0; i < len + 12; i++) begin
        if (i < 7) begin
          exp_b = 8'h55;
        end else if (i == 7) begin
          exp_b = 8'hD5;
        end else if (i < len + 8) begin
          exp_b = payload_byte(off, i - 8);
        end else begin
          exp_b = fcs[8*(i-len-8) +: 8];
        end
        if (got[i] !== exp_b) begin
          $display("[FAIL] gmii_txd frame %0d byte %0d: expected 0x%02h got 0x%02h",
                   frames_done, i, exp_b, got[i]);
          errs = errs + 1;
        end
      end
    end
    if (sched[63]) begin
      // command marks the epoch at its own release
      if (sched[62:60] != 3'd0) begin
        epoch[sched[62:60]] = first_cnt;
      end
      if (frames_done > 0 && gap != `IFG_CYCLES) begin
        $display("[FAIL] gmii_tx_en low cycles before frame %0d: expected 0x%0h got 0x%0h",
                 frames_done, `IFG_CYCLES, gap);
        errs = errs + 1;
      end
    end else begin
      target = {16'h0, sched[47:0]};
      if (sched[62:60] != 3'd0) begin
        target = target + epoch[sched[62:60]];
      end
      if (first_cnt < target) begin
        $display("[FAIL] global_counter at frame %0d start: expected >= 0x%0h got 0x%0h",
                 frames_done, target, first_cnt);
        errs = errs + 1;
      end
      if (frames_done > 0 && gap < `IFG_CYCLES) begin
        $display("[FAIL] gmii_tx_en low cycles before frame %0d: expected >= 0x%0h got 0x%0h",
                 frames_done, `IFG_CYCLES, gap);
        errs = errs + 1;
      end
    end
    exp_ptr = exp_ptr + AW'(7 + (len + 1) / 2);
    if (mem_rd_ptr !== exp_ptr) begin
      $display("[FAIL] mem_rd_ptr after frame %0d: expected 0x%0h got 0x%0h",
               frames_done, exp_ptr, mem_rd_ptr);
      errs = errs + 1;
    end
    if (frames_done == int'(tdata[0]) - 1 && mem_rd_ptr !== mem_wr_ptr) begin
      $display("[FAIL] mem_rd_ptr after last frame: expected 0x%0h got 0x%0h",
               mem_wr_ptr, mem_rd_ptr);
      errs = errs + 1;
    end
    $display("frame %0d: len %0d, first byte at counter 0x%0h, %0d errors",
             frames_done, len, first_cnt, errs);
    fail_cnt    = fail_cnt + errs;
    frames_done = frames_done + 1;
  endtask

  always @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      if (!rst_seen) begin
        frames_done = 0;
        fail_cnt    = 0;
      end else if (gmii_tx_en !== 1'b0) begin
        $display("[FAIL] gmii_tx_en during reset: expected 0x0 got 0x%0h", gmii_tx_en);
        fail_cnt = fail_cnt + 1;
      end
      rst_seen = 1'b1;
      prev_en  = 1'b0;
      low_cnt  = 0;
      exp_ptr  = '0;
      exp_cnt  = 64'd0;
      for (int k = 0; k < 8; k++) begin
        epoch[k] = 64'd0;
      end
    end else if (rst_seen) begin
      // global time counts one per clock from zero after reset
      if (global_counter !== exp_cnt) begin
        $display("[FAIL] global_counter: expected 0x%0h got 0x%0h", exp_cnt, global_counter);
        fail_cnt = fail_cnt + 1;
      end
      exp_cnt = exp_cnt + 64'd1;
      if (gmii_tx_en === 1'b1) begin
        // first byte of a burst
        if (!prev_en) begin
          first_cnt = global_counter;
          gap       = low_cnt;
          got.delete();
        end
        got.push_back(gmii_txd);
        prev_en = 1'b1;
      end else begin
        if (gmii_txd !== 8'h00) begin
          $display("[FAIL] gmii_txd while idle: expected 0x00 got 0x%02h", gmii_txd);
          fail_cnt = fail_cnt + 1;
        end
        if (prev_en) begin
          check_frame();
          low_cnt = 0;
        end
        low_cnt = low_cnt + 1;
        prev_en = 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_timed_tx.sv
`timescale 1ns/100ps
`include "timed_tx_cfg.svh"

module tb_timed_tx;

  import timed_tx_pkg::*;

  localparam int TD_WORDS = 128;
  localparam int AW = `TX_RAM_AW;

  logic          gmii_tx_clk;
  logic          sys_rst;
  host_wr_s      host_wr;
  logic          host_wr_valid;
  logic [AW-1:0] mem_wr_ptr;
  logic [AW-1:0] mem_rd_ptr;
  logic [7:0]    gmii_txd;
  logic          gmii_tx_en;
  logic [63:0]   global_counter;
  logic [15:0]   tdata [0:TD_WORDS-1];
  int            seed;
  int            cyc = 0;
  int            n_rec;
  int            wd_cycles;
  int            frames_done;
  int            fail_cnt;

  timed_tx_top timed_tx_top_inst (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .host_wr        (host_wr),
    .host_wr_valid  (host_wr_valid),
    .mem_wr_ptr     (mem_wr_ptr),
    .mem_rd_ptr     (mem_rd_ptr),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .global_counter (global_counter)
  );

  tx_checker #(.TD_WORDS(TD_WORDS)) tx_checker_inst (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .tdata          (tdata),
    .mem_wr_ptr     (mem_wr_ptr),
    .mem_rd_ptr     (mem_rd_ptr),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .global_counter (global_counter),
    .frames_done    (frames_done),
    .fail_cnt       (fail_cnt)
  );

  initial begin
    gmii_tx_clk = 1'b0;
    forever #5 gmii_tx_clk = ~gmii_tx_clk;
  end

  // cycles since reset release, write times in the data file use it
  always @(posedge gmii_tx_clk) begin
    if (!sys_rst) begin
      cyc <= cyc + 1;
    end
  end

  // one host word, 1 ns after the edge
  task automatic write_word(input logic [AW-1:0] addr, input logic [15:0] data);
    @(posedge gmii_tx_clk);
    #1;
    host_wr_valid = 1'b1;
    host_wr.addr  = addr;
    host_wr.data  = data;
  endtask

  initial begin
    int            idx;
    int            len;
    int            sum_time;
    logic [31:0]   hash;
    logic [AW-1:0] wp;
    seed          = 32'h69b0;
    sys_rst       = 1'b1;
    host_wr       = '0;
    host_wr_valid = 1'b0;
    mem_wr_ptr    = '0;
    $readmemh("tb/timed_tx_testdata.hex", tdata);
    n_rec = int'(tdata[0]);
    // budget is every release time plus a margin per frame
    sum_time = 0;
    idx      = 1;
    for (int r = 0; r < n_rec; r++) begin
      if (!tdata[idx+1][15]) begin
        sum_time = sum_time + int'({tdata[idx+3], tdata[idx+4]});
      end
      idx = idx + 6 + (int'(tdata[idx+5]) + 1) / 2;
    end
    wd_cycles = sum_time + 200 * n_rec + 8;

    repeat (8) @(posedge gmii_tx_clk);
    #1;
    sys_rst = 1'b0;

    wp  = '0;
    idx = 1;
    for (int r = 0; r < n_rec; r++) begin
      len  = int'(tdata[idx+5]);
      hash = $random(seed);
      while (cyc < int'(tdata[idx])) begin
        @(posedge gmii_tx_clk);
      end
      write_word(wp, tdata[idx+5]);
      for (int k = 0; k < 4; k++) begin
        write_word(wp + AW'(1 + k), tdata[idx+1+k]);
      end
      write_word(wp + AW'(5), hash[31:16]);
      write_word(wp + AW'(6), hash[15:0]);
      for (int k = 0; k < (len + 1) / 2; k++) begin
        write_word(wp + AW'(7 + k), tdata[idx+6+k]);
      end
      // pointer moves only once the last word is in memory
      @(posedge gmii_tx_clk);
      #1;
      host_wr_valid = 1'b0;
      wp            = wp + AW'(7 + (len + 1) / 2);
      mem_wr_ptr    = wp;
      idx           = idx + 6 + (len + 1) / 2;
    end

    while (frames_done < n_rec) begin
      @(posedge gmii_tx_clk);
    end
    // a short idle tail, so a stray frame would still be caught
    repeat (20) @(posedge gmii_tx_clk);
    $display("frames checked %0d of %0d, failed checks %0d", frames_done, n_rec, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (wd_cycles) @(posedge gmii_tx_clk);
    $display("timeout, the frames were not all sent within %0d cycles", wd_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hw
hw/timed_tx_pkg.sv
hw/tx_slot_ram.sv
hw/eth_crc32.sv
hw/timebase.sv
hw/frame_sender.sv
hw/timed_tx_top.sv
tb/tx_checker.sv
tb/tb_timed_tx.sv

// File: Makefile
# Verilator build for the timed GMII transmitter

TOOL       := verilator
TOP        := tb_timed_tx
RTL_TOP    := timed_tx_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/timed_tx_testdata.hex
// first word: record count; then per record: write cycle, schedule word (4 words, msw first),
// payload length in bytes, then payload words with the high byte sent first
0005
// time record, global select, release at 0x190
0005 0000 0000 0000 0190 000a
0102 0304 0506 0708 090a
// command record, marks local clock 3
0014 b000 0000 0000 0000 0007
1122 3344 5566 7700
// time record on local clock 3, 0x100 after its epoch
001e 3000 0000 0000 0100 0005
a1b2 c3d4 e500
// time record already due, goes out after the minimum gap
0028 0000 0000 0000 0000 0002
dead
// command record with select 0, no epoch is marked
0032 8000 0000 0000 0000 0001
5a00
